//--- design/bp_types_pkg.sv
package bp_types_pkg;

    // --------------------
    // Address widths
    // --------------------

    // Every instruction address and every branch target is a full
    // 32-bit byte address
    localparam int unsigned ADDR_BITS = 32;

    // Compressed instructions sit on 16-bit boundaries, so only bit 0
    // carries no information and the table index starts at bit 1
    localparam int unsigned INDEX_LSB = 1;

    // --------------------
    // Vector types
    // --------------------

    // Program counters from fetch, resolved branch addresses from execute
    // and stored targets all use this one type
    typedef logic [ADDR_BITS-1:0] addr_t;

    // The index and tag widths depend on the table depth, which is a
    // module parameter, so each table derives them locally from
    // ADDR_BITS and INDEX_LSB

endpackage : bp_types_pkg

//--- design/bp_msg_pkg.sv
package bp_msg_pkg;

    import bp_types_pkg::*;

    // --------------------
    // Fetch side
    // --------------------

    // Lookup request from fetch, the strobe travels beside it
    typedef struct packed {
        addr_t pc;
    } lookup_req_t;

    // Prediction returned to fetch one cycle after the lookup
    // is_branch reports the kind held in the buffer, a miss leaves it stale
    typedef struct packed {
        logic  hit;
        logic  taken;
        logic  is_branch;
        addr_t target;
    } bp_pred_t;

    // --------------------
    // Execute side
    // --------------------

    // A resolved control transfer, exactly one of is_branch and is_jump
    // is expected to be set when the update strobe is high
    typedef struct packed {
        addr_t instr_address;
        addr_t target;
        logic  taken;
        logic  is_branch;
        logic  is_jump;
    } bp_update_t;

    // --------------------
    // Direction counters
    // --------------------

    // The upper bit of the encoding is the predicted direction
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } counter_state_e;

endpackage : bp_msg_pkg

//--- design/branch_target_buffer.sv
`timescale 1ns/1ps

module branch_target_buffer #(
    parameter int unsigned INDEX_BITS = 6
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    // Lookup port from fetch
    input  logic                   rd_en_i,
    input  bp_types_pkg::addr_t    rd_pc_i,

    // Resolved branch from execute
    input  logic                   wr_en_i,
    input  bp_msg_pkg::bp_update_t wr_update_i,

    // Registered lookup result
    output logic                   hit_o,
    output logic                   is_branch_o,
    output bp_types_pkg::addr_t    target_o
);

    import bp_types_pkg::*;
    import bp_msg_pkg::*;

    // --------------------
    // Geometry
    // --------------------

    localparam int unsigned ENTRIES  = 2 ** INDEX_BITS;
    localparam int unsigned TAG_LSB  = INDEX_LSB + INDEX_BITS;
    localparam int unsigned TAG_BITS = ADDR_BITS - TAG_LSB;

    // Payload of one entry, the valid bit lives apart so it can be reset
    typedef struct packed {
        logic                is_branch;
        logic [TAG_BITS-1:0] tag;
        addr_t               target;
    } btb_entry_t;

    btb_entry_t          mem [ENTRIES];
    logic [ENTRIES-1:0]  valid_q;

    logic [INDEX_BITS-1:0] rd_idx;
    logic [INDEX_BITS-1:0] wr_idx;
    logic [TAG_BITS-1:0]   wr_tag;
    logic                  wr_alloc;

    // Index from bit 1 upward, tag from the bits above the index
    assign rd_idx = rd_pc_i[INDEX_LSB +: INDEX_BITS];
    assign wr_idx = wr_update_i.instr_address[INDEX_LSB +: INDEX_BITS];
    assign wr_tag = wr_update_i.instr_address[ADDR_BITS-1 -: TAG_BITS];

    // Only a transfer that actually redirected fetch earns an entry
    // A not-taken branch still trains its counter elsewhere
    assign wr_alloc = wr_en_i && wr_update_i.taken
                      && (wr_update_i.is_branch || wr_update_i.is_jump);

    // --------------------
    // Write port
    // --------------------

    // A matching index is simply overwritten, there is one way only
    always_ff @(posedge clk_i) begin
        if (wr_alloc) begin
            mem[wr_idx] <= '{is_branch: wr_update_i.is_branch,
                             tag:       wr_tag,
                             target:    wr_update_i.target};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (wr_alloc) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // --------------------
    // Read port
    // --------------------

    btb_entry_t          rd_entry_q;
    logic                rd_valid_q;
    logic [TAG_BITS-1:0] rd_tag_q;

    // The entry is sampled with the old table contents, so a write in the
    // same cycle is only seen by the next lookup
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_entry_q <= mem[rd_idx];
            rd_tag_q   <= rd_pc_i[ADDR_BITS-1 -: TAG_BITS];
        end
    end

    // Without a lookup the previous result is held
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_valid_q <= 1'b0;
        end else if (rd_en_i) begin
            rd_valid_q <= valid_q[rd_idx];
        end
    end

    // Tag compare happens after the register, against the saved lookup tag
    assign hit_o       = rd_valid_q && (rd_entry_q.tag == rd_tag_q);
    assign is_branch_o = rd_entry_q.is_branch;
    assign target_o    = rd_entry_q.target;

endmodule : branch_target_buffer

//--- design/bimodal_counter_table.sv
`timescale 1ns/1ps

module bimodal_counter_table #(
    parameter int unsigned INDEX_BITS = 6
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    // Lookup port from fetch
    input  logic                       rd_en_i,
    input  bp_types_pkg::addr_t        rd_pc_i,

    // Resolved branch from execute
    input  logic                       upd_en_i,
    input  bp_msg_pkg::bp_update_t     upd_i,

    // Registered counter of the looked-up pc
    output bp_msg_pkg::counter_state_e state_o
);

    import bp_types_pkg::*;
    import bp_msg_pkg::*;

    localparam int unsigned ENTRIES = 2 ** INDEX_BITS;

    // --------------------
    // Counter stepping
    // --------------------

    // Moves one state in the resolved direction and sticks at either end
    function automatic counter_state_e step_counter(
        input counter_state_e cur,
        input logic           taken
    );
        counter_state_e nxt;
        nxt = cur;
        case (cur)
            STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT;
            WEAK_NT:   nxt = taken ? WEAK_T   : STRONG_NT;
            WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
            STRONG_T:  nxt = taken ? STRONG_T : WEAK_T;
            default:   nxt = WEAK_NT;
        endcase
        return nxt;
    endfunction

    // --------------------
    // Counter array
    // --------------------

    counter_state_e        ctr_q [ENTRIES];
    logic [INDEX_BITS-1:0] rd_idx;
    logic [INDEX_BITS-1:0] upd_idx;
    logic                  upd_train;

    // Same index bits as the target buffer, but no tag, so aliasing
    // branches share one counter
    assign rd_idx  = rd_pc_i[INDEX_LSB +: INDEX_BITS];
    assign upd_idx = upd_i.instr_address[INDEX_LSB +: INDEX_BITS];

    // Jumps are always taken and never touch the counters
    assign upd_train = upd_en_i && upd_i.is_branch;

    // Every counter starts weakly not taken
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= WEAK_NT;
            end
        end else if (upd_train) begin
            ctr_q[upd_idx] <= step_counter(ctr_q[upd_idx], upd_i.taken);
        end
    end

    // --------------------
    // Read register
    // --------------------

    // Reads see the array before a same-cycle update lands
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_o <= WEAK_NT;
        end else if (rd_en_i) begin
            state_o <= ctr_q[rd_idx];
        end
    end

endmodule : bimodal_counter_table

//--- design/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor #(
    parameter int unsigned INDEX_BITS = 6
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    // Lookup strobe and pc from fetch
    input  logic                    lookup_valid_i,
    input  bp_msg_pkg::lookup_req_t lookup_i,

    // Resolved branch from execute
    input  logic                    update_valid_i,
    input  bp_msg_pkg::bp_update_t  update_i,

    // Prediction back to fetch, one cycle after the lookup
    output logic                    pred_valid_o,
    output bp_msg_pkg::bp_pred_t    pred_o
);

    import bp_types_pkg::*;
    import bp_msg_pkg::*;

    logic           btb_hit;
    logic           btb_is_branch;
    addr_t          btb_target;
    counter_state_e ctr_state;
    logic           ctr_taken;

    // --------------------
    // Tables
    // --------------------

    // Both tables see the same pc and the same update, so their results
    // line up in the same cycle
    branch_target_buffer #(
        .INDEX_BITS (INDEX_BITS)
    ) u_btb (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rd_en_i     (lookup_valid_i),
        .rd_pc_i     (lookup_i.pc),
        .wr_en_i     (update_valid_i),
        .wr_update_i (update_i),
        .hit_o       (btb_hit),
        .is_branch_o (btb_is_branch),
        .target_o    (btb_target)
    );

    bimodal_counter_table #(
        .INDEX_BITS (INDEX_BITS)
    ) u_bct (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .rd_en_i  (lookup_valid_i),
        .rd_pc_i  (lookup_i.pc),
        .upd_en_i (update_valid_i),
        .upd_i    (update_i),
        .state_o  (ctr_state)
    );

    // --------------------
    // Merge
    // --------------------

    // Result valid follows the lookup strobe by exactly one cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pred_valid_o <= 1'b0;
        end else begin
            pred_valid_o <= lookup_valid_i;
        end
    end

    // Both taken states of the counter predict taken
    assign ctr_taken = (ctr_state == WEAK_T) || (ctr_state == STRONG_T);

    // A stored jump overrides the counter, a miss never predicts taken
    assign pred_o.hit       = btb_hit;
    assign pred_o.taken     = btb_hit && (!btb_is_branch || ctr_taken);
    assign pred_o.is_branch = btb_is_branch;
    assign pred_o.target    = btb_target;

endmodule : branch_predictor

//--- bench/bp_vectors.svh
`ifndef BP_VECTORS_SVH
`define BP_VECTORS_SVH

// --------------------
// Row format
// --------------------

// One clock step of stimulus with the prediction expected one cycle later
typedef struct packed {
    logic        grp_start;
    logic        lk_valid;
    lookup_req_t lk;
    logic        up_valid;
    bp_update_t  up;
    logic        chk;
    bp_pred_t    exp;
} vec_row_t;

// Update kinds packed as {taken, is_branch, is_jump}
localparam logic [2:0] UPD_NONE  = 3'b000;
localparam logic [2:0] UPD_JMP   = 3'b101;
localparam logic [2:0] UPD_BR_T  = 3'b110;
localparam logic [2:0] UPD_BR_NT = 3'b010;

// Expected results packed as {hit, taken, is_branch}
localparam logic [2:0] MISS      = 3'b000;
localparam logic [2:0] HIT_JMP   = 3'b110;
localparam logic [2:0] HIT_BR_T  = 3'b111;
localparam logic [2:0] HIT_BR_NT = 3'b101;

vec_row_t rows[$];
logic     group_pending = 1'b0;
int       group_count = 0;

// Marks the next row as the first of a new group
task automatic next_group();
    group_pending = 1'b1;
    group_count++;
endtask

// Columns are lookup strobe, lookup pc, update kind, update pc, update target,
// expected result and expected target, which only counts on a hit
task automatic add_row(input logic lk, input addr_t pc, input logic [2:0] upd,
                       input addr_t upd_pc, input addr_t upd_tgt,
                       input logic [2:0] exp, input addr_t exp_tgt);
    vec_row_t r;
    r = '0;
    r.grp_start = group_pending;
    r.lk_valid = lk;
    r.lk.pc = pc;
    r.up_valid = (upd != UPD_NONE);
    r.up.instr_address = upd_pc;
    r.up.target = upd_tgt;
    {r.up.taken, r.up.is_branch, r.up.is_jump} = upd;
    r.chk = lk;
    {r.exp.hit, r.exp.taken, r.exp.is_branch} = exp;
    r.exp.target = exp_tgt;
    rows.push_back(r);
    group_pending = 1'b0;
endtask

// With 64 entries the index is pc[6:1], so 1000, 1010, 1022, 1104, 1208,
// 1316 and 2034 map to 0, 8, 17, 2, 4, 11 and 26, and 3034 aliases 2034
task automatic load_vectors();
    // Fresh tables miss everywhere
    next_group();
    add_row(1'b1, 32'h1000, UPD_NONE, 32'h0, 32'h0, MISS, 32'h0);
    add_row(1'b1, 32'h1010, UPD_NONE, 32'h0, 32'h0, MISS, 32'h0);
    add_row(1'b0, 32'h0, UPD_NONE, 32'h0, 32'h0, MISS, 32'h0);
    add_row(1'b1, 32'h1022, UPD_NONE, 32'h0, 32'h0, MISS, 32'h0);
    // A jump lands at the edge, so the lookup beside it still misses
    next_group();
    add_row(1'b1, 32'h1104, UPD_JMP, 32'h1104, 32'h4000, MISS, 32'h0);
    add_row(1'b1, 32'h1104, UPD_NONE, 32'h0, 32'h0, HIT_JMP, 32'h4000);
    // Counter walks WEAK_NT, WEAK_T, WEAK_NT, STRONG_NT
    // Not-taken updates carry another target that must never be stored
    next_group();
    add_row(1'b0, 32'h0, UPD_BR_T, 32'h1208, 32'h5000, MISS, 32'h0);
    add_row(1'b1, 32'h1208, UPD_NONE, 32'h0, 32'h0, HIT_BR_T, 32'h5000);
    add_row(1'b0, 32'h0, UPD_BR_NT, 32'h1208, 32'h5100, MISS, 32'h0);
    add_row(1'b1, 32'h1208, UPD_NONE, 32'h0, 32'h0, HIT_BR_NT, 32'h5000);
    add_row(1'b0, 32'h0, UPD_BR_NT, 32'h1208, 32'h5100, MISS, 32'h0);
    add_row(1'b1, 32'h1208, UPD_NONE, 32'h0, 32'h0, HIT_BR_NT, 32'h5000);
    // Four taken steps reach STRONG_T and push once against the top
    add_row(1'b0, 32'h0, UPD_BR_T, 32'h1208, 32'h5000, MISS, 32'h0);
    add_row(1'b0, 32'h0, UPD_BR_T, 32'h1208, 32'h5000, MISS, 32'h0);
    add_row(1'b0, 32'h0, UPD_BR_T, 32'h1208, 32'h5000, MISS, 32'h0);
    add_row(1'b0, 32'h0, UPD_BR_T, 32'h1208, 32'h5000, MISS, 32'h0);
    add_row(1'b0, 32'h0, UPD_BR_NT, 32'h1208, 32'h5100, MISS, 32'h0);
    add_row(1'b1, 32'h1208, UPD_NONE, 32'h0, 32'h0, HIT_BR_T, 32'h5000);
    // Not taken on a fresh pc trains but never allocates
    next_group();
    add_row(1'b0, 32'h0, UPD_BR_NT, 32'h1316, 32'h6000, MISS, 32'h0);
    add_row(1'b1, 32'h1316, UPD_NONE, 32'h0, 32'h0, MISS, 32'h0);
    // Same index with another tag replaces the entry
    next_group();
    add_row(1'b0, 32'h0, UPD_JMP, 32'h2034, 32'h7000, MISS, 32'h0);
    add_row(1'b1, 32'h2034, UPD_NONE, 32'h0, 32'h0, HIT_JMP, 32'h7000);
    add_row(1'b1, 32'h3034, UPD_BR_T, 32'h3034, 32'h8000, MISS, 32'h0);
    add_row(1'b1, 32'h3034, UPD_NONE, 32'h0, 32'h0, HIT_BR_T, 32'h8000);
    add_row(1'b1, 32'h2034, UPD_NONE, 32'h0, 32'h0, MISS, 32'h0);
    // A lookup on every cycle, one of them beside a training update
    next_group();
    add_row(1'b1, 32'h1104, UPD_NONE, 32'h0, 32'h0, HIT_JMP, 32'h4000);
    add_row(1'b1, 32'h1208, UPD_BR_NT, 32'h1208, 32'h5100, HIT_BR_T, 32'h5000);
    add_row(1'b1, 32'h1208, UPD_NONE, 32'h0, 32'h0, HIT_BR_NT, 32'h5000);
    add_row(1'b1, 32'h3034, UPD_NONE, 32'h0, 32'h0, HIT_BR_T, 32'h8000);
    add_row(1'b1, 32'h2034, UPD_NONE, 32'h0, 32'h0, MISS, 32'h0);
    add_row(1'b1, 32'h1316, UPD_NONE, 32'h0, 32'h0, MISS, 32'h0);
    add_row(1'b1, 32'h1000, UPD_NONE, 32'h0, 32'h0, MISS, 32'h0);
endtask

`endif

//--- bench/branch_predictor_tb.sv
`timescale 1ns/1ps

module branch_predictor_tb;

    import bp_types_pkg::*;
    import bp_msg_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 8;

    logic        clk_i;
    logic        rst_n_i;
    logic        lookup_valid_i;
    lookup_req_t lookup_i;
    logic        update_valid_i;
    bp_update_t  update_i;
    logic        pred_valid_o;
    bp_pred_t    pred_o;

    `include "bp_vectors.svh"

    vec_row_t    prev_row;
    vec_row_t    idle_row;
    int          errors = 0;
    int          checks = 0;
    int          watchdog_cycles = 0;
    int unsigned gap;

    branch_predictor #(
        .INDEX_BITS (6)
    ) dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .lookup_valid_i (lookup_valid_i),
        .lookup_i       (lookup_i),
        .update_valid_i (update_valid_i),
        .update_i       (update_i),
        .pred_valid_o   (pred_valid_o),
        .pred_o         (pred_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // --------------------
    // Checking
    // --------------------

    // Outputs are read at the falling edge, half a cycle after they settle
    task automatic check_result(input vec_row_t r);
        checks++;
        if (pred_valid_o !== r.lk_valid) begin
            $display("Error at %0d ns: pred_valid_o expected %0b got %0b",
                     $time, r.lk_valid, pred_valid_o);
            errors++;
        end
        if (r.chk) begin
            if (pred_o.hit !== r.exp.hit) begin
                $display("Error at %0d ns: pred_o.hit expected %0b got %0b",
                         $time, r.exp.hit, pred_o.hit);
                errors++;
            end
            if (pred_o.taken !== r.exp.taken) begin
                $display("Error at %0d ns: pred_o.taken expected %0b got %0b",
                         $time, r.exp.taken, pred_o.taken);
                errors++;
            end
            // Kind and target are stale on a miss and only matter on a hit
            if (r.exp.hit && (pred_o.is_branch !== r.exp.is_branch)) begin
                $display("Error at %0d ns: pred_o.is_branch expected %0b got %0b",
                         $time, r.exp.is_branch, pred_o.is_branch);
                errors++;
            end
            if (r.exp.hit && (pred_o.target !== r.exp.target)) begin
                $display("Error at %0d ns: pred_o.target expected %h got %h",
                         $time, r.exp.target, pred_o.target);
                errors++;
            end
        end
    endtask

    // Drives one row at the rising edge and checks the row before it
    task automatic apply_row(input vec_row_t r);
        @(posedge clk_i);
        lookup_valid_i <= r.lk_valid;
        lookup_i       <= r.lk;
        update_valid_i <= r.up_valid;
        update_i       <= r.up;
        @(negedge clk_i);
        check_result(prev_row);
        prev_row = r;
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        lookup_valid_i = 1'b0;
        lookup_i = '0;
        update_valid_i = 1'b0;
        update_i = '0;
        idle_row = '0;
        prev_row = '0;
        void'($urandom(88));
        load_vectors();
        watchdog_cycles = rows.size() + RESET_CYCLES + 3 * group_count + 20;

        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            // Idle rows strobe nothing, so the expected table state holds
            if (rows[i].grp_start && (i != 0)) begin
                gap = $urandom % 4;
                repeat (gap) apply_row(idle_row);
            end
            apply_row(rows[i]);
        end
        // One more step lets the last lookup show its result
        apply_row(idle_row);

        $display("Finished %0d rows with %0d checks and %0d errors",
                 rows.size(), checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // The limit covers every row, the reset and the longest idle gaps
    initial begin
        wait (watchdog_cycles != 0);
        #(watchdog_cycles * CLK_PERIOD);
        $display("Timeout after %0d cycles, the vector loop never finished",
                 watchdog_cycles);
        $display("Checks failed");
        $finish;
    end

endmodule : branch_predictor_tb

//--- vlog.f
+incdir+bench
design/bp_types_pkg.sv
design/bp_msg_pkg.sv
design/branch_target_buffer.sv
design/bimodal_counter_table.sv
design/branch_predictor.sv
bench/branch_predictor_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compiles the branch predictor testbench with Verilator and runs it.
# The exit status is non-zero on a build error, a crash, or a failing check.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build/obj_dir
TOP=branch_predictor_tb
LOG=sim.log

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Could not create $BUILD_DIR"
    exit 1
fi

verilator --binary --timing --timescale 1ns/1ps \
    --top-module "$TOP" \
    -f vlog.f \
    -Mdir "$BUILD_DIR" \
    -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    echo "Simulation FAILED, see $LOG"
    exit 1
fi

echo "Simulation PASSED"
exit 0
